// ==== include/engine_config_config.svh ====
// --------------------------------------------------------------------------
// Engine configuration loader constants
// Word and field widths, FIFO depth and the size of the index window
// --------------------------------------------------------------------------

`ifndef ENGINE_CONFIG_CONFIG_SVH
`define ENGINE_CONFIG_CONFIG_SVH

// Memory response word
`define ECFG_DATA_W      32
`define ECFG_OFFSET_W    16
`define ECFG_SHIFT_W     5

// Words per configuration record, also the window size
`define ECFG_SEQ_LEN     16

// Default depth of both FIFOs
`define ECFG_FIFO_DEPTH  16

// Array pointer, assembled from two data words
`define ECFG_PTR_W       64

// Route identifier fields of the target
`define ECFG_ID_W        4

`endif

// ==== design/engine_config_pkg.sv ====
// --------------------------------------------------------------------------
// Engine configuration types
// Buffer classes, memory commands, the response word and the
// read/write configuration record, plus the sequence index helpers
// --------------------------------------------------------------------------

`include "engine_config_config.svh"

package engine_config_pkg;

    // Buffer class carried by every response word
    typedef enum logic [3:0] {
        class_invalid      = 4'd0,
        class_cu_setup     = 4'd1,
        class_engine_setup = 4'd2,
        class_edge_data    = 4'd3
    } buffer_class_t;

    typedef enum logic [1:0] {
        cmd_invalid = 2'd0,
        cmd_read    = 2'd1,
        cmd_write   = 2'd2,
        cmd_stream  = 2'd3
    } memory_cmd_t;

    typedef logic [`ECFG_OFFSET_W-1:0] seq_index_t;

    // One memory response transfer
    typedef struct packed {
        buffer_class_t             buffer_class;
        logic [`ECFG_OFFSET_W-1:0] offset;
        logic [`ECFG_SHIFT_W-1:0]  shift_amount;
        logic [`ECFG_DATA_W-1:0]   data;
    } response_word_t;

    // Read/write configuration record
    typedef struct packed {
        logic                      increment;
        logic                      decrement;
        logic                      mode_sequence;
        logic                      mode_buffer;
        logic [`ECFG_DATA_W-1:0]   index_start;
        logic [`ECFG_DATA_W-1:0]   index_end;
        logic [`ECFG_DATA_W-1:0]   stride;
        // Doubles as the shift amount
        logic [`ECFG_DATA_W-2:0]   granularity;
        logic                      shift_direction;
        memory_cmd_t               cmd;
        buffer_class_t             target_class;
        logic [`ECFG_ID_W-1:0]     target_cu;
        logic [`ECFG_ID_W-1:0]     target_bundle;
        logic [`ECFG_ID_W-1:0]     target_lane;
        logic [`ECFG_PTR_W-1:0]    array_pointer;
        logic [`ECFG_DATA_W-1:0]   array_size;
    } config_record_t;

    // Sequence index is the offset scaled down by the shift amount
    function automatic seq_index_t seq_index_of(input response_word_t w);
        return w.offset >> w.shift_amount;
    endfunction

    function automatic logic is_setup_class(input buffer_class_t c);
        return (c == class_cu_setup) || (c == class_engine_setup);
    endfunction

endpackage

// ==== design/payload_fifo.sv ====
// --------------------------------------------------------------------------
// Synchronous FIFO with a type-parameter payload
// Circular buffer with valid/ready on both sides and an almost-full flag
// --------------------------------------------------------------------------

`include "engine_config_config.svh"

module payload_fifo #(
    parameter type payload_t = logic [`ECFG_DATA_W-1:0],
    parameter int  depth     = `ECFG_FIFO_DEPTH
) (
    input  logic     ap_clk,
    input  logic     arst_n,
    input  logic     push_valid,
    output logic     push_ready,
    input  payload_t push_data,
    output logic     pop_valid,
    input  logic     pop_ready,
    output payload_t pop_data,
    output logic     almost_full
);

    localparam int ptr_w   = (depth > 1) ? $clog2(depth) : 1;
    localparam int level_w = $clog2(depth + 1);

    payload_t           mem [depth];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [level_w-1:0] level;
    logic               do_push;
    logic               do_pop;

    // Pointer wrap for any depth, not only powers of two
    function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] p);
        if (p == ptr_w'(depth - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign push_ready  = (level != level_w'(depth));
    assign pop_valid   = (level != '0);
    assign almost_full = (level >= level_w'(depth - 2));
    assign pop_data    = mem[rd_ptr];

    assign do_push = push_valid & push_ready;
    assign do_pop  = pop_valid & pop_ready;

    always_ff @(posedge ap_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            // Level stays put on a simultaneous push and pop
            case ({do_push, do_pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    // Storage
    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

// ==== design/setup_response_filter.sv ====
// --------------------------------------------------------------------------
// Setup response filter
// One register stage in front of the response FIFO that keeps only
// setup-class words whose sequence index lies in the engine window
// --------------------------------------------------------------------------

`include "engine_config_config.svh"

module setup_response_filter #(
    parameter int window_base = 0
) (
    input  logic                             ap_clk,
    input  logic                             arst_n,
    input  logic                             in_valid,
    output logic                             in_ready,
    input  engine_config_pkg::response_word_t in_word,
    output logic                             fifo_valid,
    input  logic                             fifo_ready,
    output engine_config_pkg::response_word_t fifo_word
);

    localparam int unsigned win_lo = window_base;
    localparam int unsigned win_hi = window_base + `ECFG_SEQ_LEN;

    logic                              stage_valid;
    engine_config_pkg::response_word_t stage_word;
    engine_config_pkg::seq_index_t     stage_index;
    logic                              in_window;
    logic                              keep;
    logic                              stage_done;

    // --------------------------------------------------------------------------
    // Filter decision on the registered word
    // --------------------------------------------------------------------------
    assign stage_index = engine_config_pkg::seq_index_of(stage_word);
    assign in_window   = (32'(stage_index) >= win_lo) && (32'(stage_index) < win_hi);
    assign keep        = engine_config_pkg::is_setup_class(stage_word.buffer_class) && in_window;

    // Rejected words leave at once, kept words wait for FIFO room
    assign stage_done = stage_valid & (~keep | fifo_ready);
    assign in_ready   = ~stage_valid | stage_done;

    assign fifo_valid = stage_valid & keep;
    assign fifo_word  = stage_word;

    // --------------------------------------------------------------------------
    // Stage register
    // --------------------------------------------------------------------------
    always_ff @(posedge ap_clk or negedge arst_n) begin
        if (!arst_n) begin
            stage_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            stage_valid <= 1'b1;
        end else if (stage_done) begin
            stage_valid <= 1'b0;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (in_valid && in_ready) begin
            stage_word <= in_word;
        end
    end

endmodule

// ==== design/config_word_sequencer.sv ====
// --------------------------------------------------------------------------
// Configuration word sequencer
// Pops window words in index order, writes each into its record field
// and hands the finished record to the output FIFO after the last index
// --------------------------------------------------------------------------

`include "engine_config_config.svh"

module config_word_sequencer #(
    parameter int window_base = 0
) (
    input  logic                              ap_clk,
    input  logic                              arst_n,
    input  logic                              word_valid,
    output logic                              word_ready,
    input  engine_config_pkg::response_word_t word,
    input  logic                              room_low,
    output logic                              rec_valid,
    input  logic                              rec_ready,
    output engine_config_pkg::config_record_t rec
);

    localparam int               rel_w    = $clog2(`ECFG_SEQ_LEN);
    localparam logic [rel_w-1:0] last_idx = rel_w'(`ECFG_SEQ_LEN - 1);

    engine_config_pkg::seq_index_t rel_full;
    logic [rel_w-1:0]              rel_idx;
    logic                          in_window;
    logic                          armed;
    logic [rel_w-1:0]              expect_idx;
    logic                          pop;
    logic                          start;
    logic                          match;
    logic                          capture;

    // --------------------------------------------------------------------------
    // Index decode
    // --------------------------------------------------------------------------
    assign rel_full  = engine_config_pkg::seq_index_of(word)
                     - engine_config_pkg::seq_index_t'(window_base);
    assign rel_idx   = rel_full[rel_w-1:0];
    assign in_window = (rel_full < engine_config_pkg::seq_index_t'(`ECFG_SEQ_LEN));

    // Hold off while the output side is nearly full or a record waits
    assign word_ready = ~room_low & ~rec_valid;
    assign pop        = word_valid & word_ready;

    // Index 0 always opens a record, others must be the expected one
    assign start   = in_window & (rel_idx == '0);
    assign match   = in_window & armed & (rel_idx == expect_idx);
    assign capture = pop & (start | match);

    // --------------------------------------------------------------------------
    // Sequence tracking
    // --------------------------------------------------------------------------
    always_ff @(posedge ap_clk or negedge arst_n) begin
        if (!arst_n) begin
            armed      <= 1'b0;
            expect_idx <= '0;
            rec_valid  <= 1'b0;
        end else begin
            if (rec_valid && rec_ready) begin
                rec_valid <= 1'b0;
            end
            if (pop) begin
                if (start) begin
                    armed      <= 1'b1;
                    expect_idx <= rel_w'(1);
                end else if (match && (rel_idx == last_idx)) begin
                    armed     <= 1'b0;
                    rec_valid <= 1'b1;
                end else if (match) begin
                    expect_idx <= expect_idx + 1'b1;
                end else begin
                    // Skipped or repeated index drops the partial record
                    armed <= 1'b0;
                end
            end
        end
    end

    // --------------------------------------------------------------------------
    // Field map
    // --------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (capture) begin
            case (rel_idx)
                rel_w'(0): begin
                    rec.increment     <= word.data[0];
                    rec.decrement     <= word.data[1];
                    rec.mode_sequence <= word.data[2];
                    rec.mode_buffer   <= word.data[3];
                end
                rel_w'(1): rec.index_start <= word.data;
                rel_w'(2): rec.index_end   <= word.data;
                rel_w'(3): rec.stride      <= word.data;
                rel_w'(4): begin
                    rec.granularity     <= word.data[`ECFG_DATA_W-2:0];
                    rec.shift_direction <= word.data[`ECFG_DATA_W-1];
                end
                rel_w'(5): begin
                    rec.cmd          <= engine_config_pkg::memory_cmd_t'(word.data[1:0]);
                    rec.target_class <= engine_config_pkg::buffer_class_t'(word.data[5:2]);
                end
                rel_w'(7): begin
                    rec.target_cu     <= word.data[`ECFG_ID_W-1:0];
                    rec.target_bundle <= word.data[2*`ECFG_ID_W-1:`ECFG_ID_W];
                    rec.target_lane   <= word.data[3*`ECFG_ID_W-1:2*`ECFG_ID_W];
                end
                rel_w'(8):  rec.array_pointer[`ECFG_DATA_W-1:0] <= word.data;
                rel_w'(9):  rec.array_pointer[`ECFG_PTR_W-1:`ECFG_DATA_W] <= word.data;
                rel_w'(10): rec.array_size <= word.data;
                // Slots 6 and 11 to 15 carry nothing
                default: ;
            endcase
        end
    end

endmodule

// ==== design/engine_config_loader.sv ====
// --------------------------------------------------------------------------
// Engine configuration loader
// Filters memory responses, queues them, assembles read/write
// configuration records and queues those for the engine
// --------------------------------------------------------------------------

`include "engine_config_config.svh"

module engine_config_loader #(
    parameter int window_base = 0
) (
    input  logic                              ap_clk,
    input  logic                              arst_n,
    input  logic                              in_valid,
    output logic                              in_ready,
    input  engine_config_pkg::response_word_t in_word,
    output logic                              out_valid,
    input  logic                              out_ready,
    output engine_config_pkg::config_record_t out_record
);

    // Filter to response FIFO
    logic                              resp_valid;
    logic                              resp_ready;
    engine_config_pkg::response_word_t resp_word;

    // Response FIFO to sequencer
    logic                              seq_valid;
    logic                              seq_ready;
    engine_config_pkg::response_word_t seq_word;

    // Sequencer to output FIFO
    logic                              rec_valid;
    logic                              rec_ready;
    engine_config_pkg::config_record_t rec;
    logic                              room_low;

    setup_response_filter #(
        .window_base (window_base)
    ) u_filter (
        .ap_clk     (ap_clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_word    (in_word),
        .fifo_valid (resp_valid),
        .fifo_ready (resp_ready),
        .fifo_word  (resp_word)
    );

    payload_fifo #(
        .payload_t (engine_config_pkg::response_word_t),
        .depth     (`ECFG_FIFO_DEPTH)
    ) u_response_fifo (
        .ap_clk      (ap_clk),
        .arst_n      (arst_n),
        .push_valid  (resp_valid),
        .push_ready  (resp_ready),
        .push_data   (resp_word),
        .pop_valid   (seq_valid),
        .pop_ready   (seq_ready),
        .pop_data    (seq_word),
        .almost_full ()
    );

    config_word_sequencer #(
        .window_base (window_base)
    ) u_sequencer (
        .ap_clk     (ap_clk),
        .arst_n     (arst_n),
        .word_valid (seq_valid),
        .word_ready (seq_ready),
        .word       (seq_word),
        .room_low   (room_low),
        .rec_valid  (rec_valid),
        .rec_ready  (rec_ready),
        .rec        (rec)
    );

    // Read side is the loader output
    payload_fifo #(
        .payload_t (engine_config_pkg::config_record_t),
        .depth     (`ECFG_FIFO_DEPTH)
    ) u_record_fifo (
        .ap_clk      (ap_clk),
        .arst_n      (arst_n),
        .push_valid  (rec_valid),
        .push_ready  (rec_ready),
        .push_data   (rec),
        .pop_valid   (out_valid),
        .pop_ready   (out_ready),
        .pop_data    (out_record),
        .almost_full (room_low)
    );

endmodule

// ==== bench/config_checker.sv ====
// --------------------------------------------------------------------------
// Configuration loader checker
// Models the setup filter and word sequence on every accepted input word
// and compares each output record with the expected one, field by field
// --------------------------------------------------------------------------

`include "engine_config_config.svh"

module config_checker #(
    parameter int window_base = 0
) (
    input  logic                              ap_clk,
    input  logic                              arst_n,
    input  logic                              in_valid,
    input  logic                              in_ready,
    input  engine_config_pkg::response_word_t in_word,
    input  logic                              out_valid,
    input  logic                              out_ready,
    input  engine_config_pkg::config_record_t out_record,
    input  logic [2:0]                        test_id,
    input  logic                              end_check,
    output int                                pending,
    output int                                mismatch_count,
    output int                                other_count
);
    timeunit 1ns;
    timeprecision 1ps;

    engine_config_pkg::config_record_t exp_records[$];
    logic [2:0]                        exp_tests[$];
    engine_config_pkg::config_record_t building;
    logic                              armed = 1'b0;
    int                                expect_idx = 0;
    int                                checked = 0;
    logic                              end_seen = 1'b0;
    logic                              reset_checked = 1'b0;
    logic                              stall_seen = 1'b0;

    initial begin
        pending        = 0;
        mismatch_count = 0;
        other_count    = 0;
    end

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd1:    return "clean_records";
            3'd2:    return "filtering";
            3'd3:    return "shift";
            3'd4:    return "abort";
            3'd5:    return "backpressure";
            default: return "unknown";
        endcase
    endfunction

    // Reference field map, one word into its slot of the record
    function automatic engine_config_pkg::config_record_t apply_field(
        input engine_config_pkg::config_record_t r,
        input int                                rel,
        input logic [31:0]                       d
    );
        case (rel)
            0: {r.mode_buffer, r.mode_sequence, r.decrement, r.increment} = d[3:0];
            1: r.index_start = d;
            2: r.index_end = d;
            3: r.stride = d;
            4: {r.shift_direction, r.granularity} = d;
            5: begin
                r.cmd          = engine_config_pkg::memory_cmd_t'(d[1:0]);
                r.target_class = engine_config_pkg::buffer_class_t'(d[5:2]);
            end
            7: {r.target_lane, r.target_bundle, r.target_cu} = d[11:0];
            8: r.array_pointer[31:0] = d;
            9: r.array_pointer[63:32] = d;
            10: r.array_size = d;
            default: ;
        endcase
        return r;
    endfunction

    task automatic model_word(input engine_config_pkg::response_word_t w,
                              input logic [2:0] id);
        int  idx;
        int  rel;
        logic setup;
        idx   = int'(w.offset >> w.shift_amount);
        setup = (w.buffer_class == engine_config_pkg::class_cu_setup)
             || (w.buffer_class == engine_config_pkg::class_engine_setup);
        if (!setup || idx < window_base || idx >= window_base + `ECFG_SEQ_LEN) begin
            return;
        end
        rel = idx - window_base;
        if (rel == 0) begin
            armed      = 1'b1;
            expect_idx = 1;
            building   = apply_field('0, 0, w.data);
        end else if (armed && rel == expect_idx) begin
            building = apply_field(building, rel, w.data);
            if (rel == `ECFG_SEQ_LEN - 1) begin
                exp_records.push_back(building);
                exp_tests.push_back(id);
                armed = 1'b0;
            end else begin
                expect_idx++;
            end
        end else begin
            armed = 1'b0;
        end
    endtask

    task automatic check_field(input logic [2:0] id, input string field,
                               input logic [63:0] expected, input logic [63:0] actual);
        if (expected !== actual) begin
            mismatch_count++;
            $display("FAIL %s record %0d %s expected 0x%0h actual 0x%0h",
                     test_name(id), checked, field, expected, actual);
        end
    endtask

    task automatic compare_record(input engine_config_pkg::config_record_t got);
        engine_config_pkg::config_record_t e;
        logic [2:0]                        id;
        if (exp_records.size() == 0) begin
            other_count++;
            $display("ERROR: the DUT put out a record that no input sequence completed");
            return;
        end
        e  = exp_records.pop_front();
        id = exp_tests.pop_front();
        check_field(id, "flags", {e.increment, e.decrement, e.mode_sequence, e.mode_buffer},
                    {got.increment, got.decrement, got.mode_sequence, got.mode_buffer});
        check_field(id, "index_start", e.index_start, got.index_start);
        check_field(id, "index_end", e.index_end, got.index_end);
        check_field(id, "stride", e.stride, got.stride);
        check_field(id, "granularity", e.granularity, got.granularity);
        check_field(id, "shift_direction", e.shift_direction, got.shift_direction);
        check_field(id, "cmd", e.cmd, got.cmd);
        check_field(id, "target_class", e.target_class, got.target_class);
        check_field(id, "target_cu", e.target_cu, got.target_cu);
        check_field(id, "target_bundle", e.target_bundle, got.target_bundle);
        check_field(id, "target_lane", e.target_lane, got.target_lane);
        check_field(id, "array_pointer", e.array_pointer, got.array_pointer);
        check_field(id, "array_size", e.array_size, got.array_size);
        checked++;
    endtask

    // Both transfers are taken from the values present at the edge
    always @(posedge ap_clk) begin
        if (arst_n) begin
            // Empty filter stage and empty output FIFO right out of reset
            if (!reset_checked) begin
                reset_checked = 1'b1;
                if (!in_ready || out_valid) begin
                    other_count++;
                    $display("ERROR: in_ready low or out_valid high on the first cycle after reset");
                end
            end
            if (test_id == 3'd5 && in_valid && !in_ready) begin
                stall_seen = 1'b1;
            end
            if (in_valid && in_ready) begin
                model_word(in_word, test_id);
            end
            if (out_valid && out_ready) begin
                compare_record(out_record);
            end
            if (end_check && !end_seen) begin
                end_seen = 1'b1;
                if (exp_records.size() != 0) begin
                    other_count++;
                    $display("ERROR: %0d expected records never came out of the DUT",
                             exp_records.size());
                end
                if (checked == 0) begin
                    other_count++;
                    $display("ERROR: no output record was checked at all");
                end
                if (!stall_seen) begin
                    other_count++;
                    $display("ERROR: in_ready never dropped while the output side was held off");
                end
            end
        end
        pending = exp_records.size();
    end

endmodule

// ==== bench/tb_engine_config_loader.sv ====
// --------------------------------------------------------------------------
// Engine configuration loader testbench
// Builds LFSR-driven response word sequences, drives them into the DUT
// and reports the checker's result
// --------------------------------------------------------------------------

`include "engine_config_config.svh"

module tb_engine_config_loader;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          window_base = 16;
    localparam logic [31:0] lfsr_seed   = 32'he96c7112;
    localparam int          stall_hold  = 600;
    localparam int          drain_limit = 2000;

    logic                              ap_clk = 1'b0;
    logic                              arst_n;
    logic                              in_valid;
    logic                              in_ready;
    engine_config_pkg::response_word_t in_word;
    logic                              out_valid;
    logic                              out_ready;
    engine_config_pkg::config_record_t out_record;
    logic [2:0]                        test_id;
    logic                              end_check;
    int                                pending;
    int                                mismatch_count;
    int                                other_count;

    logic [31:0]                       lfsr_state = lfsr_seed;
    int                                hold_cycles = 0;
    int                                stim_count = 0;
    engine_config_pkg::response_word_t stim_words[$];
    logic [2:0]                        stim_tests[$];
    int                                stim_gaps[$];

    always #5 ap_clk = ~ap_clk;

    engine_config_loader #(
        .window_base (window_base)
    ) uut (
        .ap_clk     (ap_clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_word    (in_word),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_record (out_record)
    );

    config_checker #(
        .window_base (window_base)
    ) u_checker (
        .ap_clk         (ap_clk),
        .arst_n         (arst_n),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_word        (in_word),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_record     (out_record),
        .test_id        (test_id),
        .end_check      (end_check),
        .pending        (pending),
        .mismatch_count (mismatch_count),
        .other_count    (other_count)
    );

    // ----------------------------------------------------------------------------
    // Random source, Galois LFSR x^32+x^22+x^2+x+1
    // ----------------------------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits       = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return bits;
    endfunction

    // Offset carries the index scaled up, with random bits below the shift
    task automatic queue_word(input engine_config_pkg::buffer_class_t cls, input int index,
                              input int shift, input logic [2:0] id);
        engine_config_pkg::response_word_t w;
        logic [15:0]                       low_mask;
        low_mask       = (16'd1 << shift) - 16'd1;
        w.buffer_class = cls;
        w.offset       = 16'(index << shift) | (16'(rand_bits(16)) & low_mask);
        w.shift_amount = 5'(shift);
        w.data         = rand_bits(32);
        stim_words.push_back(w);
        stim_tests.push_back(id);
        stim_gaps.push_back((rand_bits(2) == 0) ? 1 : 0);
    endtask

    // Edge data or setup words that lie outside the window
    task automatic queue_junk(input logic [2:0] id);
        case (rand_bits(2))
            0: queue_word(engine_config_pkg::class_edge_data,
                          window_base + int'(rand_bits(4)), 0, id);
            1: queue_word(engine_config_pkg::class_invalid,
                          window_base + int'(rand_bits(4)), 0, id);
            2: queue_word(engine_config_pkg::class_cu_setup, int'(rand_bits(4)), 0, id);
            default: queue_word(engine_config_pkg::class_engine_setup,
                                window_base + `ECFG_SEQ_LEN + int'(rand_bits(4)), 0, id);
        endcase
    endtask

    task automatic queue_sequence(input logic [2:0] id, input int first, input int last,
                                  input logic shifted, input logic junk);
        engine_config_pkg::buffer_class_t cls;
        int                               shift;
        for (int idx = first; idx <= last; idx++) begin
            if (junk && rand_bits(1)) begin
                queue_junk(id);
            end
            cls   = rand_bits(1) ? engine_config_pkg::class_engine_setup
                                 : engine_config_pkg::class_cu_setup;
            shift = shifted ? 1 + int'(rand_bits(4)) % 10 : 0;
            queue_word(cls, window_base + idx, shift, id);
        end
    endtask

    task automatic build_stimulus();
        repeat (4) queue_sequence(3'd1, 0, 15, 1'b0, 1'b0);
        repeat (3) queue_sequence(3'd2, 0, 15, 1'b0, 1'b1);
        repeat (3) queue_sequence(3'd3, 0, 15, 1'b1, 1'b0);
        // Skipped index, repeated index, then restart in the middle
        queue_sequence(3'd4, 0, 6, 1'b0, 1'b0);
        queue_sequence(3'd4, 8, 15, 1'b0, 1'b0);
        queue_sequence(3'd4, 0, 15, 1'b0, 1'b0);
        queue_sequence(3'd4, 0, 4, 1'b0, 1'b0);
        queue_sequence(3'd4, 4, 15, 1'b0, 1'b0);
        queue_sequence(3'd4, 0, 15, 1'b0, 1'b0);
        queue_sequence(3'd4, 0, 9, 1'b0, 1'b0);
        queue_sequence(3'd4, 0, 15, 1'b0, 1'b0);
        repeat (20) queue_sequence(3'd5, 0, 15, 1'b0, 1'b0);
        stim_count = stim_words.size();
    endtask

    // Output side held off first in the back-pressure test, then random
    always @(posedge ap_clk) begin
        if (test_id == 3'd5) begin
            hold_cycles <= hold_cycles + 1;
        end
        if (test_id != 3'd5) begin
            out_ready <= 1'b1;
        end else if (hold_cycles < stall_hold) begin
            out_ready <= 1'b0;
        end else begin
            out_ready <= (rand_bits(1) != 0);
        end
    end

    initial begin
        int limit_cycles;
        wait (stim_count > 0);
        limit_cycles = 40 * stim_count + 1000;
        repeat (limit_cycles) @(posedge ap_clk);
        $display("ERROR: watchdog ran out after %0d cycles, the run did not finish",
                 limit_cycles);
        $display("Test failures found");
        $finish;
    end

    initial begin
        int drain;
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        in_word   = '0;
        out_ready = 1'b0;
        test_id   = 3'd0;
        end_check = 1'b0;
        build_stimulus();
        repeat (10) @(posedge ap_clk);
        arst_n <= 1'b1;
        @(posedge ap_clk);
        for (int i = 0; i < stim_count; i++) begin
            if (stim_gaps[i] > 0) begin
                in_valid <= 1'b0;
                repeat (stim_gaps[i]) @(posedge ap_clk);
            end
            in_valid <= 1'b1;
            in_word  <= stim_words[i];
            test_id  <= stim_tests[i];
            @(posedge ap_clk);
            while (!in_ready) @(posedge ap_clk);
        end
        in_valid <= 1'b0;
        @(negedge ap_clk);
        drain = 0;
        while (pending != 0 && drain < drain_limit) begin
            @(negedge ap_clk);
            drain++;
        end
        // Room for any record beyond the expected ones to show up
        repeat (50) @(posedge ap_clk);
        end_check <= 1'b1;
        @(posedge ap_clk);
        @(negedge ap_clk);
        $display("Closing: %0d value mismatches, %0d other errors",
                 mismatch_count, other_count);
        if (mismatch_count + other_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+include
design/engine_config_pkg.sv
design/payload_fifo.sv
design/setup_response_filter.sv
design/config_word_sequencer.sv
design/engine_config_loader.sv
bench/config_checker.sv
bench/tb_engine_config_loader.sv
